//--- Makefile
TOOL      = verilator
TOP       = alu_unit_tb
FILELIST  = compile.f
BUILD_DIR = obj_dir
FLAGS     = --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(BUILD_DIR)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

# The simulator exits with a failing status when the testbench stops on an error
test:
	$(TOOL) $(FLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- compile.f
hdl/alu_pkg.sv
hdl/alu_shifter.sv
hdl/alu_multiplier.sv
hdl/alu_issue.sv
hdl/alu_execute.sv
hdl/alu_result.sv
hdl/alu_unit.sv
testbench/alu_unit_tb.sv

//--- hdl/alu_execute.sv
module alu_execute import alu_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     stall,
	input  logic     op_valid,
	input  exec_op_t op,
	output logic     res_valid,
	output result_t  res
);

	// One entry of the delay line that runs beside the multiplier
	typedef struct packed {
		tag_t tag;
		unit_sel_t unit;
		logic high;
		logic illegal;
		value_t value;
	} line_t;

	value_t shift_out;
	value_t single;
	double_value_t product;
	line_t line [MUL_STAGES];
	logic [MUL_STAGES-1:0] line_valid;
	line_t last;

	alu_shifter i_alu_shifter
	(
		.a(op.a),
		.amount(op.amount),
		.func(shift_func_t'(op.sub)),
		.result(shift_out)
	);

	alu_multiplier i_alu_multiplier
	(
		.clk(clk),
		.stall(stall),
		.a(op.a),
		.b(op.b),
		.signed_mul(op.signed_mul),
		.product(product)
	);

	// ============================================================
	// Single-cycle datapath
	// ============================================================

	always_comb
	begin
		case (op.unit)
		UNIT_ARITH:
			case (op.sub)
			SUB_SUB:
				single = op.a - op.b;
			SUB_SLT:
				single = value_t'($signed(op.a) < $signed(op.b));
			SUB_SLTU:
				single = value_t'(op.a < op.b);
			SUB_SEQ:
				single = value_t'(op.a == op.b);
			default:
				single = op.a + op.b;
			endcase
		UNIT_LOGIC:
			case (op.sub)
			SUB_OR:
				single = op.a | op.b;
			SUB_EOR:
				single = op.a ^ op.b;
			default:
				single = op.a & op.b;
			endcase
		UNIT_SHIFT:
			single = shift_out;
		UNIT_PASS:
			single = op.b;
		// The product is picked up at the end of the line instead
		default:
			single = '0;
		endcase
	end

	// ============================================================
	// Delay line kept in step with the multiplier
	// ============================================================

	always_ff @(posedge clk)
	begin
		if (reset)
			line_valid <= '0;
		else if (!stall)
			line_valid <= {line_valid[MUL_STAGES-2:0], op_valid};
	end

	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			line[0].tag <= op.tag;
			line[0].unit <= op.unit;
			line[0].high <= op.high;
			line[0].illegal <= op.illegal;
			line[0].value <= single;
			for (int i = 1; i < MUL_STAGES; i++)
				line[i] <= line[i-1];
		end
	end

	// Result select at the tail of the line
	always_comb
	begin
		last = line[MUL_STAGES-1];
		res_valid = line_valid[MUL_STAGES-1];
		res.tag = last.tag;
		res.illegal = last.illegal;
		if (last.illegal)
			res.value = ILLEGAL_VALUE;
		else if (last.unit == UNIT_MUL)
			res.value = last.high ? product[127:64] : product[63:0];
		else
			res.value = last.value;
	end

	// The issue stage must always hand over a decoded unit
	assert property (@(posedge clk) disable iff (reset)
		op_valid |-> !$isunknown(op.unit)
			&& op.unit inside {UNIT_ARITH, UNIT_LOGIC, UNIT_SHIFT, UNIT_MUL, UNIT_PASS});

endmodule

//--- hdl/alu_issue.sv
module alu_issue import alu_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     in_valid,
	output logic     in_ready,
	input  issue_t   in_data,
	input  logic     stall,
	output logic     op_valid,
	output exec_op_t op
);

	exec_op_t dec;

	// The whole pipe freezes together, so the input is only open when it moves
	assign in_ready = !stall;

	// ============================================================
	// Decode of the instruction union
	// ============================================================

	always_comb
	begin
		dec.tag = in_data.tag;
		dec.unit = UNIT_PASS;
		dec.sub = SUB_ADD;
		dec.a = in_data.a;
		dec.b = in_data.b;
		dec.signed_mul = 1'b0;
		dec.high = 1'b0;
		dec.illegal = 1'b0;
		// The shift view is read for every opcode and only matters to OP_SHIFT
		dec.amount = in_data.instr.shift.imm ? in_data.instr.shift.amount : in_data.b[5:0];
		case (in_data.instr.any.opcode)
		OP_R2:
			case (in_data.instr.r2.func)
			FN_ADD:
			begin
				dec.unit = UNIT_ARITH;
				dec.sub = SUB_ADD;
			end
			FN_SUB:
			begin
				dec.unit = UNIT_ARITH;
				dec.sub = SUB_SUB;
			end
			FN_SLT:
			begin
				dec.unit = UNIT_ARITH;
				dec.sub = SUB_SLT;
			end
			FN_SLTU:
			begin
				dec.unit = UNIT_ARITH;
				dec.sub = SUB_SLTU;
			end
			FN_SEQ:
			begin
				dec.unit = UNIT_ARITH;
				dec.sub = SUB_SEQ;
			end
			FN_AND:
			begin
				dec.unit = UNIT_LOGIC;
				dec.sub = SUB_AND;
			end
			FN_OR:
			begin
				dec.unit = UNIT_LOGIC;
				dec.sub = SUB_OR;
			end
			FN_EOR:
			begin
				dec.unit = UNIT_LOGIC;
				dec.sub = SUB_EOR;
			end
			// Multiplies differ only in operand sign and the half returned
			FN_MUL:
			begin
				dec.unit = UNIT_MUL;
				dec.signed_mul = 1'b1;
			end
			FN_MULU:
				dec.unit = UNIT_MUL;
			FN_MULH:
			begin
				dec.unit = UNIT_MUL;
				dec.signed_mul = 1'b1;
				dec.high = 1'b1;
			end
			FN_MULUH:
			begin
				dec.unit = UNIT_MUL;
				dec.high = 1'b1;
			end
			default:
				dec.illegal = 1'b1;
			endcase
		// Immediate forms reuse the register datapath with b taken from imm
		OP_ADDI:
		begin
			dec.unit = UNIT_ARITH;
			dec.sub = SUB_ADD;
			dec.b = in_data.imm;
		end
		OP_ANDI:
		begin
			dec.unit = UNIT_LOGIC;
			dec.sub = SUB_AND;
			dec.b = in_data.imm;
		end
		OP_ORI:
		begin
			dec.unit = UNIT_LOGIC;
			dec.sub = SUB_OR;
			dec.b = in_data.imm;
		end
		OP_SHIFT:
		begin
			dec.unit = UNIT_SHIFT;
			dec.sub = in_data.instr.shift.func;
			dec.illegal = !(in_data.instr.shift.func inside {SH_ASL, SH_LSR, SH_ASR,
				SH_ROL, SH_ROR});
		end
		// Pass forms all return b, so b is loaded with the value to write
		OP_LDI:
			dec.b = in_data.imm;
		OP_MOV:
			dec.b = in_data.a;
		OP_JSR:
			dec.b = value_t'(in_data.pc) + LINK_OFFSET;
		default:
			dec.illegal = 1'b1;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			op_valid <= 1'b0;
		else if (!stall)
			op_valid <= in_valid;
	end

	always_ff @(posedge clk)
	begin
		if (!stall && in_valid)
			op <= dec;
	end

	// An instruction held back by a stall must wait unchanged until it is taken
	assert property (@(posedge clk) disable iff (reset)
		in_valid && !in_ready |=> in_valid && $stable(in_data));

endmodule

//--- hdl/alu_multiplier.sv
module alu_multiplier import alu_pkg::*;
(
	input  logic          clk,
	input  logic          stall,
	input  value_t        a,
	input  value_t        b,
	input  logic          signed_mul,
	output double_value_t product
);

	// Operands widened by one bit so one signed multiplier covers both forms
	logic signed [64:0] a_ext;
	logic signed [64:0] b_ext;

	// Raw product before the output register
	double_value_t prod_mid;

	// ============================================================
	// Three stages: operand register, multiply, output register
	// ============================================================

	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			// Unsigned operands get a zero top bit, signed ones a copy of bit 63
			a_ext <= {signed_mul & a[63], a};
			b_ext <= {signed_mul & b[63], b};
		end
	end

	always_ff @(posedge clk)
	begin
		if (!stall)
			// The low 128 bits of the 65x65 signed product are the exact result
			prod_mid <= a_ext * b_ext;
	end

	always_ff @(posedge clk)
	begin
		if (!stall)
			product <= prod_mid;
	end

endmodule

//--- hdl/alu_pkg.sv
package alu_pkg;

	// ============================================================
	// Basic word types
	// ============================================================

	typedef logic [63:0] value_t;
	typedef logic [127:0] double_value_t;
	typedef logic [31:0] pc_address_t;
	typedef logic [4:0] tag_t;

	// Every instruction spends this many cycles in the execute stage
	localparam int MUL_STAGES = 3;

	// Written for any encoding that the unit does not recognise
	localparam value_t ILLEGAL_VALUE = {2{32'hDEADBEEF}};

	// The link register gets the call address plus the call length
	localparam value_t LINK_OFFSET = 64'd5;

	// ============================================================
	// Instruction encoding
	// ============================================================

	typedef enum logic [6:0] {
		OP_R2    = 7'h02,
		OP_ADDI  = 7'h04,
		OP_ANDI  = 7'h08,
		OP_ORI   = 7'h09,
		OP_SHIFT = 7'h0C,
		OP_LDI   = 7'h10,
		OP_MOV   = 7'h11,
		OP_JSR   = 7'h14
	} opcode_t;

	typedef enum logic [5:0] {
		FN_ADD   = 6'h04,
		FN_SUB   = 6'h05,
		FN_AND   = 6'h08,
		FN_OR    = 6'h09,
		FN_EOR   = 6'h0A,
		FN_SLT   = 6'h10,
		FN_SLTU  = 6'h11,
		FN_SEQ   = 6'h12,
		FN_MUL   = 6'h18,
		FN_MULU  = 6'h19,
		FN_MULH  = 6'h1A,
		FN_MULUH = 6'h1B
	} r2_func_t;

	typedef enum logic [2:0] {
		SH_ASL = 3'd0,
		SH_LSR = 3'd1,
		SH_ASR = 3'd2,
		SH_ROL = 3'd3,
		SH_ROR = 3'd4
	} shift_func_t;

	// The opcode sits in the low seven bits of every view
	typedef union packed {
		struct packed {
			logic [24:0] unused;
			opcode_t opcode;
		} any;
		struct packed {
			logic [18:0] unused;
			r2_func_t func;
			opcode_t opcode;
		} r2;
		struct packed {
			logic [14:0] unused;
			logic [5:0] amount;
			logic imm;
			shift_func_t func;
			opcode_t opcode;
		} shift;
	} instruction_t;

	// ============================================================
	// Stream words and internal control
	// ============================================================

	typedef struct packed {
		tag_t tag;
		instruction_t instr;
		value_t a;
		value_t b;
		value_t imm;
		pc_address_t pc;
	} issue_t;

	typedef enum logic [2:0] {
		UNIT_ARITH,
		UNIT_LOGIC,
		UNIT_SHIFT,
		UNIT_MUL,
		UNIT_PASS
	} unit_sel_t;

	// Subfunction codes for the arithmetic unit
	localparam logic [2:0] SUB_ADD  = 3'd0;
	localparam logic [2:0] SUB_SUB  = 3'd1;
	localparam logic [2:0] SUB_SLT  = 3'd2;
	localparam logic [2:0] SUB_SLTU = 3'd3;
	localparam logic [2:0] SUB_SEQ  = 3'd4;

	// Subfunction codes for the logic unit
	localparam logic [2:0] SUB_AND = 3'd0;
	localparam logic [2:0] SUB_OR  = 3'd1;
	localparam logic [2:0] SUB_EOR = 3'd2;

	typedef struct packed {
		tag_t tag;
		unit_sel_t unit;
		logic [2:0] sub;
		value_t a;
		value_t b;
		logic [5:0] amount;
		logic signed_mul;
		logic high;
		logic illegal;
	} exec_op_t;

	typedef struct packed {
		tag_t tag;
		value_t value;
		logic illegal;
	} result_t;

endpackage

//--- hdl/alu_result.sv
module alu_result import alu_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    res_valid,
	input  result_t res,
	output logic    out_valid,
	input  logic    out_ready,
	output result_t out_data,
	output logic    stall
);

	logic skid_valid;
	result_t skid_data;
	logic accept;
	logic main_free;

	// The upstream pipe only freezes once the spare entry is taken
	assign stall = skid_valid;

	// A result is taken whenever the pipe is moving
	assign accept = res_valid && !stall;

	// Main register can be loaded when empty or being read this cycle
	assign main_free = !out_valid || out_ready;

	// ============================================================
	// Main register and skid entry
	// ============================================================

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			out_valid <= 1'b0;
			skid_valid <= 1'b0;
		end
		else if (main_free)
		begin
			// The skid entry is older, so it drains first
			if (skid_valid)
			begin
				out_valid <= 1'b1;
				skid_valid <= 1'b0;
			end
			else
				out_valid <= accept;
		end
		else if (accept)
			skid_valid <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (main_free)
		begin
			if (skid_valid)
				out_data <= skid_data;
			else if (accept)
				out_data <= res;
		end
		else if (accept)
			skid_data <= res;
	end

	// A result that is offered but not taken must stay exactly as it was
	assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

//--- hdl/alu_shifter.sv
module alu_shifter import alu_pkg::*;
(
	input  value_t      a,
	input  logic [5:0]  amount,
	input  shift_func_t func,
	output value_t      result
);

	// Three-word funnels with the operand in the middle word
	logic [191:0] shl;
	logic [191:0] shr;
	logic [191:0] asr;

	// Bits shifted out on the left land in the top word
	always_comb
		shl = {64'd0, a, 64'd0} << amount;

	// Bits shifted out on the right land in the bottom word
	always_comb
		shr = {64'd0, a, 64'd0} >> amount;

	// Sign copies in the top word fill in behind an arithmetic shift
	always_comb
		asr = {{64{a[63]}}, a, 64'd0} >> amount;

	always_comb
	begin
		case (func)
		SH_ASL:
			result = shl[127:64];
		SH_LSR:
			result = shr[127:64];
		SH_ASR:
			result = asr[127:64];
		// A rotate folds the overflow word back onto the shifted word
		SH_ROL:
			result = shl[127:64] | shl[191:128];
		SH_ROR:
			result = shr[127:64] | shr[63:0];
		default:
			result = shl[127:64];
		endcase
	end

endmodule

//--- hdl/alu_unit.sv
module alu_unit import alu_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    in_valid,
	output logic    in_ready,
	input  issue_t  in_data,
	output logic    out_valid,
	input  logic    out_ready,
	output result_t out_data
);

	logic stall;
	logic op_valid;
	exec_op_t op;
	logic res_valid;
	result_t res;

	// Issue register, then MUL_STAGES of execute, then the output register
	alu_issue i_alu_issue
	(
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_data(in_data),
		.stall(stall),
		.op_valid(op_valid),
		.op(op)
	);

	alu_execute i_alu_execute
	(
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.op_valid(op_valid),
		.op(op),
		.res_valid(res_valid),
		.res(res)
	);

	// Stall from here freezes both stages in front of it
	alu_result i_alu_result
	(
		.clk(clk),
		.reset(reset),
		.res_valid(res_valid),
		.res(res),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_data(out_data),
		.stall(stall)
	);

endmodule

//--- testbench/alu_unit_tb.sv
module alu_unit_tb import alu_pkg::*;
();

	// ============================================================
	// Run constants and the stimulus table
	// ============================================================

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_TESTS = 49;
	localparam int PASSES = 2;
	localparam int WATCHDOG_CYCLES = PASSES * NUM_TESTS * 40;

	// Issue register, MUL_STAGES execute registers and the output register;
	// counted from the accepting edge to the edge that takes the result
	localparam int RESULT_LATENCY = 2 + MUL_STAGES;

	localparam logic [31:0] GALOIS_TAPS = 32'hA300_0000;

	// Shift functions widened to the width of the table's function column
	localparam logic [5:0] F_ASL = 6'(SH_ASL);
	localparam logic [5:0] F_LSR = 6'(SH_LSR);
	localparam logic [5:0] F_ASR = 6'(SH_ASR);
	localparam logic [5:0] F_ROL = 6'(SH_ROL);
	localparam logic [5:0] F_ROR = 6'(SH_ROR);

	// In rnd, bit 1 replaces a and bit 0 replaces b with LFSR words
	typedef struct packed {
		logic [6:0] op;
		logic [5:0] func;
		logic sh_imm;
		logic [5:0] amount;
		logic [1:0] rnd;
		value_t a;
		value_t b;
		value_t imm;
	} entry_t;

	typedef struct {
		result_t res;
		int accept_edge;
	} expected_t;

	entry_t tests [NUM_TESTS] = '{
		'{OP_R2, FN_ADD, 1'b0, 6'd0, 2'b00, 64'h7FFF_FFFF_FFFF_FFFF, 64'd1, 64'd0},
		'{OP_R2, FN_ADD, 1'b0, 6'd0, 2'b11, 64'd0, 64'd0, 64'd0},
		'{OP_R2, FN_SUB, 1'b0, 6'd0, 2'b00, 64'd5, 64'd7, 64'd0},
		'{OP_R2, FN_SUB, 1'b0, 6'd0, 2'b11, 64'd0, 64'd0, 64'd0},
		'{OP_R2, FN_AND, 1'b0, 6'd0, 2'b11, 64'd0, 64'd0, 64'd0},
		'{OP_R2, FN_OR, 1'b0, 6'd0, 2'b11, 64'd0, 64'd0, 64'd0},
		'{OP_R2, FN_EOR, 1'b0, 6'd0, 2'b11, 64'd0, 64'd0, 64'd0},
		'{OP_R2, FN_SLT, 1'b0, 6'd0, 2'b00, 64'hFFFF_FFFF_FFFF_FFFF, 64'd1, 64'd0},
		'{OP_R2, FN_SLT, 1'b0, 6'd0, 2'b00, 64'd1, 64'hFFFF_FFFF_FFFF_FFFF, 64'd0},
		'{OP_R2, FN_SLTU, 1'b0, 6'd0, 2'b00, 64'hFFFF_FFFF_FFFF_FFFF, 64'd1, 64'd0},
		'{OP_R2, FN_SLTU, 1'b0, 6'd0, 2'b00, 64'd1, 64'hFFFF_FFFF_FFFF_FFFF, 64'd0},
		'{OP_R2, FN_SEQ, 1'b0, 6'd0, 2'b00, 64'h1234_5678_9ABC_DEF0, 64'h1234_5678_9ABC_DEF0, 64'd0},
		'{OP_R2, FN_SEQ, 1'b0, 6'd0, 2'b11, 64'd0, 64'd0, 64'd0},
		'{OP_ADDI, 6'd0, 1'b0, 6'd0, 2'b10, 64'd0, 64'd3, 64'hFFFF_FFFF_FFFF_FFF0},
		'{OP_ANDI, 6'd0, 1'b0, 6'd0, 2'b10, 64'd0, 64'd3, 64'h0000_FFFF_0000_FF00},
		'{OP_ORI, 6'd0, 1'b0, 6'd0, 2'b10, 64'd0, 64'd3, 64'h8000_0000_0000_0001},
		// Immediate shift amounts, with b set to a value that must be ignored
		'{OP_SHIFT, F_ASL, 1'b1, 6'd0, 2'b10, 64'd0, 64'd7, 64'd0},
		'{OP_SHIFT, F_ASL, 1'b1, 6'd63, 2'b10, 64'd0, 64'd7, 64'd0},
		'{OP_SHIFT, F_LSR, 1'b1, 6'd63, 2'b10, 64'd0, 64'd7, 64'd0},
		'{OP_SHIFT, F_ASR, 1'b1, 6'd63, 2'b00, 64'h8000_0000_0000_0001, 64'd7, 64'd0},
		'{OP_SHIFT, F_ASR, 1'b1, 6'd0, 2'b00, 64'h8000_0000_0000_0001, 64'd7, 64'd0},
		'{OP_SHIFT, F_ASR, 1'b1, 6'd13, 2'b10, 64'd0, 64'd7, 64'd0},
		'{OP_SHIFT, F_ROL, 1'b1, 6'd1, 2'b10, 64'd0, 64'd7, 64'd0},
		'{OP_SHIFT, F_ROL, 1'b1, 6'd63, 2'b10, 64'd0, 64'd7, 64'd0},
		'{OP_SHIFT, F_ROR, 1'b1, 6'd0, 2'b10, 64'd0, 64'd7, 64'd0},
		'{OP_SHIFT, F_ROR, 1'b1, 6'd63, 2'b10, 64'd0, 64'd7, 64'd0},
		'{OP_SHIFT, F_ROR, 1'b1, 6'd17, 2'b10, 64'd0, 64'd7, 64'd0},
		// Register shift amounts, with a decoy in the amount field
		'{OP_SHIFT, F_ASL, 1'b0, 6'd9, 2'b11, 64'd0, 64'd0, 64'd0},
		'{OP_SHIFT, F_LSR, 1'b0, 6'd9, 2'b11, 64'd0, 64'd0, 64'd0},
		'{OP_SHIFT, F_ASR, 1'b0, 6'd9, 2'b01, 64'hF000_0000_0000_00F0, 64'd0, 64'd0},
		'{OP_SHIFT, F_ROL, 1'b0, 6'd9, 2'b11, 64'd0, 64'd0, 64'd0},
		'{OP_SHIFT, F_ROR, 1'b0, 6'd9, 2'b11, 64'd0, 64'd0, 64'd0},
		'{OP_SHIFT, F_LSR, 1'b0, 6'd9, 2'b10, 64'd0, 64'h40, 64'd0},
		'{OP_SHIFT, F_ROL, 1'b0, 6'd9, 2'b10, 64'd0, 64'hFFFF_FFFF_FFFF_FFFF, 64'd0},
		'{OP_SHIFT, F_ASL, 1'b0, 6'd0, 2'b10, 64'd0, 64'd63, 64'd0},
		'{OP_R2, FN_MUL, 1'b0, 6'd0, 2'b11, 64'd0, 64'd0, 64'd0},
		'{OP_R2, FN_MULU, 1'b0, 6'd0, 2'b11, 64'd0, 64'd0, 64'd0},
		'{OP_R2, FN_MULH, 1'b0, 6'd0, 2'b11, 64'd0, 64'd0, 64'd0},
		'{OP_R2, FN_MULUH, 1'b0, 6'd0, 2'b11, 64'd0, 64'd0, 64'd0},
		'{OP_R2, FN_MUL, 1'b0, 6'd0, 2'b00, 64'hFFFF_FFFF_FFFF_FFFD, 64'd5, 64'd0},
		'{OP_R2, FN_MULH, 1'b0, 6'd0, 2'b00, 64'hFFFF_FFFF_FFFF_FFFD, 64'd5, 64'd0},
		'{OP_R2, FN_MULH, 1'b0, 6'd0, 2'b00, 64'hFFFF_FFFF_FFFF_FFFF, 64'hFFFF_FFFF_FFFF_FFFF, 64'd0},
		'{OP_R2, FN_MULUH, 1'b0, 6'd0, 2'b00, 64'hFFFF_FFFF_FFFF_FFFF, 64'hFFFF_FFFF_FFFF_FFFF, 64'd0},
		'{OP_LDI, 6'd0, 1'b0, 6'd0, 2'b11, 64'd0, 64'd0, 64'hC0DE_F00D_1234_5678},
		'{OP_MOV, 6'd0, 1'b0, 6'd0, 2'b11, 64'd0, 64'd0, 64'd0},
		'{OP_JSR, 6'd0, 1'b0, 6'd0, 2'b11, 64'd0, 64'd0, 64'd0},
		// Unknown opcode, unknown register function and unknown shift function
		'{7'h7F, 6'd0, 1'b0, 6'd0, 2'b11, 64'd0, 64'd0, 64'd0},
		'{OP_R2, 6'h3F, 1'b0, 6'd0, 2'b11, 64'd0, 64'd0, 64'd0},
		'{OP_SHIFT, 6'd7, 1'b1, 6'd3, 2'b11, 64'd0, 64'd0, 64'd0}
	};

	logic clk;
	logic reset;
	logic in_valid;
	logic in_ready;
	issue_t in_data;
	logic out_valid;
	logic out_ready;
	result_t out_data;

	logic [31:0] lfsr = 32'd84;
	expected_t expected_q[$];
	tag_t next_tag = '0;
	int edge_num = 0;

	alu_unit i_alu_unit
	(
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_data(in_data),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_data(out_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ============================================================
	// Random source and reference model
	// ============================================================

	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ GALOIS_TAPS) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic value_t random_bits(int n);
		value_t v;
		int i;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			v = {v[62:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	function automatic issue_t make_issue(entry_t e, tag_t tag);
		issue_t t;
		t = '0;
		t.tag = tag;
		t.instr.any.opcode = opcode_t'(e.op);
		if (e.op == OP_SHIFT)
		begin
			t.instr.shift.func = shift_func_t'(e.func[2:0]);
			t.instr.shift.imm = e.sh_imm;
			t.instr.shift.amount = e.amount;
		end
		else
			t.instr.r2.func = r2_func_t'(e.func);
		t.a = e.rnd[1] ? random_bits(64) : e.a;
		t.b = e.rnd[0] ? random_bits(64) : e.b;
		t.imm = e.imm;
		t.pc = pc_address_t'(random_bits(32));
		return t;
	endfunction

	function automatic result_t expected_result(issue_t t);
		instruction_t ins;
		value_t a;
		value_t b;
		value_t v;
		logic [5:0] n;
		logic [127:0] prod_s;
		logic [127:0] prod_u;
		logic bad;
		result_t r;
		ins = t.instr;
		a = t.a;
		b = t.b;
		v = '0;
		bad = 1'b0;
		n = ins.shift.imm ? ins.shift.amount : b[5:0];
		// Full 128-bit products of the sign-extended and zero-extended operands
		prod_s = $signed({{64{a[63]}}, a}) * $signed({{64{b[63]}}, b});
		prod_u = {64'd0, a} * {64'd0, b};
		case (ins.any.opcode)
		OP_R2:
			case (ins.r2.func)
			FN_ADD: v = a + b;
			FN_SUB: v = a - b;
			FN_AND: v = a & b;
			FN_OR: v = a | b;
			FN_EOR: v = a ^ b;
			FN_SLT: v = {63'd0, $signed(a) < $signed(b)};
			FN_SLTU: v = {63'd0, a < b};
			FN_SEQ: v = {63'd0, a == b};
			FN_MUL: v = prod_s[63:0];
			FN_MULU: v = prod_u[63:0];
			FN_MULH: v = prod_s[127:64];
			FN_MULUH: v = prod_u[127:64];
			default: bad = 1'b1;
			endcase
		OP_ADDI: v = a + t.imm;
		OP_ANDI: v = a & t.imm;
		OP_ORI: v = a | t.imm;
		OP_SHIFT:
			case (ins.shift.func)
			SH_ASL: v = a << n;
			SH_LSR: v = a >> n;
			SH_ASR: v = value_t'($signed(a) >>> n);
			// A zero amount shifts the wrapped part out completely
			SH_ROL: v = (a << n) | (a >> (7'd64 - {1'b0, n}));
			SH_ROR: v = (a >> n) | (a << (7'd64 - {1'b0, n}));
			default: bad = 1'b1;
			endcase
		OP_LDI: v = t.imm;
		OP_MOV: v = a;
		OP_JSR: v = value_t'(t.pc) + 64'd5;
		default: bad = 1'b1;
		endcase
		r.tag = t.tag;
		r.value = bad ? ILLEGAL_VALUE : v;
		r.illegal = bad;
		return r;
	endfunction

	// ============================================================
	// Failure reporting and output checks
	// ============================================================

	task automatic stop_with_failure();
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic fail_run(string why);
		$display("Error at %0t: %s", $time, why);
		stop_with_failure();
	endtask

	task automatic report_mismatch(string name, value_t got, value_t exp);
		$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		stop_with_failure();
	endtask

	// Called at a falling edge where a transfer will happen on the next rising edge
	task automatic check_output(bit random_ready);
		expected_t exp;
		if (expected_q.size() == 0)
			fail_run("Output transfer with no instruction outstanding");
		else
		begin
			exp = expected_q.pop_front();
			assert (out_data.tag == exp.res.tag)
				else report_mismatch("out_data.tag", value_t'(out_data.tag), value_t'(exp.res.tag));
			assert (out_data.value == exp.res.value)
				else report_mismatch("out_data.value", out_data.value, exp.res.value);
			assert (out_data.illegal == exp.res.illegal)
				else report_mismatch("out_data.illegal", value_t'(out_data.illegal),
					value_t'(exp.res.illegal));
			// Exact latency only holds while the output never pushes back
			if (!random_ready)
				assert (edge_num - exp.accept_edge == RESULT_LATENCY)
					else report_mismatch("result latency", value_t'(edge_num - exp.accept_edge),
						value_t'(RESULT_LATENCY));
		end
	endtask

	// One sweep through the table, issued back to back
	task automatic run_pass(bit random_ready);
		int next;
		int delivered;
		bit taken;
		expected_t exp;
		next = 0;
		delivered = 0;
		taken = 1'b0;
		while (delivered < NUM_TESTS)
		begin
			@(negedge clk);
			edge_num++;
			out_ready = random_ready ? (random_bits(1) != '0) : 1'b1;
			if (out_valid && out_ready)
			begin
				check_output(random_ready);
				delivered++;
			end
			if (taken)
				in_valid = 1'b0;
			if (!in_valid && next < NUM_TESTS)
			begin
				in_data = make_issue(tests[next], next_tag);
				in_valid = 1'b1;
				next_tag++;
				next++;
			end
			// in_ready only moves on a rising edge, so this predicts the next transfer
			taken = in_valid && in_ready;
			if (taken)
			begin
				exp.res = expected_result(in_data);
				exp.accept_edge = edge_num;
				expected_q.push_back(exp);
			end
		end
	endtask

	// ============================================================
	// Main sequence and watchdog
	// ============================================================

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Error at %0t: watchdog expired before all results arrived", $time);
		stop_with_failure();
	end

	initial
	begin
		reset = 1'b1;
		in_valid = 1'b0;
		in_data = '0;
		out_ready = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		assert (out_valid == 1'b0)
			else report_mismatch("out_valid", value_t'(out_valid), 64'd0);
		assert (in_ready == 1'b1)
			else report_mismatch("in_ready", value_t'(in_ready), 64'd1);

		// First pass with the output always ready, second with LFSR back-pressure
		run_pass(1'b0);
		run_pass(1'b1);

		// Nothing may come out once every result has been delivered
		repeat (8)
		begin
			@(negedge clk);
			out_ready = 1'b1;
			assert (!out_valid)
				else fail_run("Extra result after all results were delivered");
		end

		if (expected_q.size() != 0)
		begin
			$display("Error at %0t: %0d results never arrived", $time, expected_q.size());
			stop_with_failure();
		end
		else
		begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule
